// ==== hw/adc_cfg_pkg.sv ====
package adc_cfg_pkg;

    // width of one conversion word
    parameter int ADC_DATA_W = 18;

    // multiplexer channel index width
    parameter int ADC_CHAN_W = 3;

    // multiplexed channels read two at a time so the count stays even
    parameter int ADC_NUM = 8;

    // cycles the capture stage keeps data valid high
    // the serializer needs at least 3 of them to finish a pair
    parameter int ADC_DV_HOLD = 4;

endpackage

// ==== hw/filter_pkg.sv ====
package filter_pkg;

    // power of two count of samples averaged into one result
    parameter int FILT_OSR = 4;

    // per channel sample counter width
    // also the right shift that turns a sum into an average
    parameter int FILT_CNT_W = $clog2(FILT_OSR);

endpackage

// ==== hw/adc_pair_capture.sv ====
`timescale 1ns/1ps

module adc_pair_capture #(
    parameter int W_DATA  = adc_cfg_pkg::ADC_DATA_W,
    parameter int W_CHAN  = adc_cfg_pkg::ADC_CHAN_W,
    parameter int N_ADC   = adc_cfg_pkg::ADC_NUM,
    parameter int DV_HOLD = adc_cfg_pkg::ADC_DV_HOLD
) (
    input  logic              sync_clk_in,
    input  logic              reset_in,

    // converter side, one strobe per finished pair
    input  logic              pair_valid,
    input  logic [W_DATA-1:0] raw_a,
    input  logic [W_DATA-1:0] raw_b,

    // towards the serializer
    output logic              dv,
    output logic [W_CHAN-1:0] chan_a,
    output logic [W_CHAN-1:0] chan_b,
    output logic [W_DATA-1:0] data_a,
    output logic [W_DATA-1:0] data_b,

    // sticky, a pair came in while the last one was still held
    output logic              overrun
);

    //////////////////////////////////////////////////////////////////////
    // local parameters and state
    //////////////////////////////////////////////////////////////////////

    localparam int N_PAIR = N_ADC / 2;
    localparam int HOLD_W = $clog2(DV_HOLD);

    // pair index k, channels 2k and 2k+1
    logic [W_CHAN-2:0] pair_idx;

    // cycles of dv left after the current one
    logic [HOLD_W-1:0] hold_cnt;

    // a strobe is only taken when nothing is being held
    logic              accept;

    assign accept = pair_valid && !dv;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sync_clk_in) begin
        if (reset_in) begin
            dv       <= 1'b0;
            hold_cnt <= '0;
            pair_idx <= '0;
            overrun  <= 1'b0;
        end else begin
            if (accept) begin
                dv       <= 1'b1;
                hold_cnt <= HOLD_W'(DV_HOLD - 1);
                // wrap after the last pair of the scan
                if (pair_idx == (W_CHAN-1)'(N_PAIR - 1)) begin
                    pair_idx <= '0;
                end else begin
                    pair_idx <= pair_idx + 1'b1;
                end
            end else if (dv) begin
                // count the hold down, drop dv once it runs out
                if (hold_cnt == '0) begin
                    dv <= 1'b0;
                end else begin
                    hold_cnt <= hold_cnt - 1'b1;
                end
            end

            // dropped strobe, remember it until reset
            if (pair_valid && dv) begin
                overrun <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // payload, tagged from the index before it advances
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sync_clk_in) begin
        if (accept) begin
            data_a <= raw_a;
            data_b <= raw_b;
            chan_a <= {pair_idx, 1'b0};
            chan_b <= {pair_idx, 1'b1};
        end
    end

endmodule

// ==== hw/clk_sync.sv ====
`timescale 1ns/1ps

module clk_sync #(
    parameter int W_DATA = adc_cfg_pkg::ADC_DATA_W,
    parameter int W_CHAN = adc_cfg_pkg::ADC_CHAN_W,
    parameter int N_ADC  = adc_cfg_pkg::ADC_NUM
) (
    input  logic              sync_clk_in,
    input  logic              reset_in,

    // pair from the capture stage, dv is a level
    input  logic              dv_in,
    input  logic [W_CHAN-1:0] chan_a_in,
    input  logic [W_CHAN-1:0] chan_b_in,
    input  logic [W_DATA-1:0] data_a_in,
    input  logic [W_DATA-1:0] data_b_in,

    // one word at a time towards the filter
    output logic [N_ADC-1:0]  dv_out,
    output logic [W_CHAN-1:0] chan_out,
    output logic [W_DATA-1:0] data_out
);

    //////////////////////////////////////////////////////////////////////
    // states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ST_WAIT_DVH = 3'd0,  // idle until dv goes high
        ST_HOLD     = 3'd1,  // pair latched, give it a cycle
        ST_SEND_A   = 3'd2,  // first word on the outputs
        ST_SEND_B   = 3'd3,  // second word on the outputs
        ST_WAIT_DVL = 3'd4   // pair done, wait for dv to drop
    } state_t;

    state_t cur_state;
    state_t next_state;

    // latched copy of the pair
    logic [W_CHAN-1:0] chan_a;
    logic [W_CHAN-1:0] chan_b;
    logic [W_DATA-1:0] data_a;
    logic [W_DATA-1:0] data_b;

    //////////////////////////////////////////////////////////////////////
    // pair latch, only on the rising edge of dv
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sync_clk_in) begin
        if (cur_state == ST_WAIT_DVH && dv_in) begin
            chan_a <= chan_a_in;
            chan_b <= chan_b_in;
            data_a <= data_a_in;
            data_b <= data_b_in;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sync_clk_in) begin
        if (reset_in) begin
            cur_state <= ST_WAIT_DVH;
        end else begin
            cur_state <= next_state;
        end
    end

    always_comb begin
        next_state = cur_state;
        case (cur_state)
            ST_WAIT_DVH: if (dv_in) next_state = ST_HOLD;
            ST_HOLD:     next_state = ST_SEND_A;
            ST_SEND_A:   next_state = ST_SEND_B;
            ST_SEND_B:   next_state = ST_WAIT_DVL;
            ST_WAIT_DVL: if (!dv_in) next_state = ST_WAIT_DVH;
            default:     next_state = ST_WAIT_DVH;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    // channel decoded to a one-hot strobe, zero outside the send states
    always_comb begin
        dv_out   = '0;
        chan_out = '0;
        data_out = '0;
        case (cur_state)
            ST_SEND_A: begin
                dv_out[chan_a] = 1'b1;
                chan_out       = chan_a;
                data_out       = data_a;
            end
            ST_SEND_B: begin
                dv_out[chan_b] = 1'b1;
                chan_out       = chan_b;
                data_out       = data_b;
            end
            default: ;
        endcase
    end

endmodule

// ==== hw/oversample_filter.sv ====
`timescale 1ns/1ps

module oversample_filter #(
    parameter int W_DATA = adc_cfg_pkg::ADC_DATA_W,
    parameter int W_CHAN = adc_cfg_pkg::ADC_CHAN_W,
    parameter int N_ADC  = adc_cfg_pkg::ADC_NUM,
    parameter int OSR    = filter_pkg::FILT_OSR
) (
    input  logic              sync_clk_in,
    input  logic              reset_in,

    // serialized samples, dv_in is one-hot per channel
    input  logic [N_ADC-1:0]  dv_in,
    input  logic [W_CHAN-1:0] chan_in,
    input  logic [W_DATA-1:0] data_in,

    // one strobe per finished average
    output logic              result_valid,
    output logic [W_CHAN-1:0] result_chan,
    output logic [W_DATA-1:0] result_data
);

    import filter_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // per channel state
    //////////////////////////////////////////////////////////////////////

    // room for OSR full scale words
    localparam int ACC_W = W_DATA + FILT_CNT_W;

    // counter value of the last sample in a block
    localparam logic [FILT_CNT_W-1:0] CNT_LAST = FILT_CNT_W'(OSR - 1);

    logic [ACC_W-1:0]      acc [N_ADC];
    logic [FILT_CNT_W-1:0] cnt [N_ADC];

    // strobed channel's sum including the new word
    logic [ACC_W-1:0]      sel_acc;
    logic [ACC_W-1:0]      next_sum;
    // strobed channel completes its block this cycle
    logic                  sel_last;

    // one-hot mux, no channel arithmetic needed
    always_comb begin
        sel_acc  = '0;
        sel_last = 1'b0;
        for (int i = 0; i < N_ADC; i++) begin
            sel_acc  = sel_acc | (acc[i] & {ACC_W{dv_in[i]}});
            sel_last = sel_last | (dv_in[i] && cnt[i] == CNT_LAST);
        end
    end

    assign next_sum = sel_acc + ACC_W'(data_in);

    //////////////////////////////////////////////////////////////////////
    // accumulate and dump
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sync_clk_in) begin
        if (reset_in) begin
            result_valid <= 1'b0;
            for (int i = 0; i < N_ADC; i++) begin
                acc[i] <= '0;
                cnt[i] <= '0;
            end
        end else begin
            result_valid <= sel_last;
            for (int i = 0; i < N_ADC; i++) begin
                if (dv_in[i]) begin
                    if (cnt[i] == CNT_LAST) begin
                        // block done, start the next one empty
                        acc[i] <= '0;
                        cnt[i] <= '0;
                    end else begin
                        acc[i] <= next_sum;
                        cnt[i] <= cnt[i] + 1'b1;
                    end
                end
            end
        end
    end

    // average is the sum with the low FILT_CNT_W bits dropped
    always_ff @(posedge sync_clk_in) begin
        if (sel_last) begin
            result_chan <= chan_in;
            result_data <= next_sum[ACC_W-1:FILT_CNT_W];
        end
    end

endmodule

// ==== hw/adc_sampler_top.sv ====
`timescale 1ns/1ps

module adc_sampler_top (
    input  logic                              sync_clk_in,
    input  logic                              reset_in,

    // converter pair interface
    input  logic                              pair_valid,
    input  logic [adc_cfg_pkg::ADC_DATA_W-1:0] raw_a,
    input  logic [adc_cfg_pkg::ADC_DATA_W-1:0] raw_b,

    // averaged results
    output logic                              result_valid,
    output logic [adc_cfg_pkg::ADC_CHAN_W-1:0] result_chan,
    output logic [adc_cfg_pkg::ADC_DATA_W-1:0] result_data,

    // sticky dropped-pair flag
    output logic                              overrun
);

    import adc_cfg_pkg::*;
    import filter_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // interconnect
    //////////////////////////////////////////////////////////////////////

    // capture to serializer
    logic                  cap_dv;
    logic [ADC_CHAN_W-1:0] cap_chan_a;
    logic [ADC_CHAN_W-1:0] cap_chan_b;
    logic [ADC_DATA_W-1:0] cap_data_a;
    logic [ADC_DATA_W-1:0] cap_data_b;

    // serializer to filter
    logic [ADC_NUM-1:0]    ser_dv;
    logic [ADC_CHAN_W-1:0] ser_chan;
    logic [ADC_DATA_W-1:0] ser_data;

    adc_pair_capture #(
        .W_DATA  (ADC_DATA_W),
        .W_CHAN  (ADC_CHAN_W),
        .N_ADC   (ADC_NUM),
        .DV_HOLD (ADC_DV_HOLD)
    ) adc_pair_capture_inst (
        .sync_clk_in (sync_clk_in),
        .reset_in    (reset_in),
        .pair_valid  (pair_valid),
        .raw_a       (raw_a),
        .raw_b       (raw_b),
        .dv          (cap_dv),
        .chan_a      (cap_chan_a),
        .chan_b      (cap_chan_b),
        .data_a      (cap_data_a),
        .data_b      (cap_data_b),
        .overrun     (overrun)
    );

    clk_sync #(
        .W_DATA (ADC_DATA_W),
        .W_CHAN (ADC_CHAN_W),
        .N_ADC  (ADC_NUM)
    ) clk_sync_inst (
        .sync_clk_in (sync_clk_in),
        .reset_in    (reset_in),
        .dv_in       (cap_dv),
        .chan_a_in   (cap_chan_a),
        .chan_b_in   (cap_chan_b),
        .data_a_in   (cap_data_a),
        .data_b_in   (cap_data_b),
        .dv_out      (ser_dv),
        .chan_out    (ser_chan),
        .data_out    (ser_data)
    );

    oversample_filter #(
        .W_DATA (ADC_DATA_W),
        .W_CHAN (ADC_CHAN_W),
        .N_ADC  (ADC_NUM),
        .OSR    (FILT_OSR)
    ) oversample_filter_inst (
        .sync_clk_in  (sync_clk_in),
        .reset_in     (reset_in),
        .dv_in        (ser_dv),
        .chan_in      (ser_chan),
        .data_in      (ser_data),
        .result_valid (result_valid),
        .result_chan  (result_chan),
        .result_data  (result_data)
    );

endmodule

// ==== bench/adc_sampler_tb.sv ====
`timescale 1ns/1ps

module adc_sampler_tb;

    import adc_cfg_pkg::*;
    import filter_pkg::*;

    // cycles a pending result may take to show up
    localparam int DRAIN_LIMIT = 64;
    // quiet cycles checked after a reset and at the end
    localparam int IDLE_CYCLES = 4;

    logic                  sync_clk_in;
    logic                  reset_in;
    logic                  pair_valid;
    logic [ADC_DATA_W-1:0] raw_a;
    logic [ADC_DATA_W-1:0] raw_b;
    logic                  result_valid;
    logic [ADC_CHAN_W-1:0] result_chan;
    logic [ADC_DATA_W-1:0] result_data;
    logic                  overrun;

    // reference model state
    int   sums [ADC_NUM];
    int   cnts [ADC_NUM];
    int   pair_k;
    logic model_ovr;
    bit   has_accepted;
    // edges since the last accepted pair was sampled
    int   elapsed;

    // results the DUT still owes
    int pend_chan [$];
    int pend_data [$];
    // every modeled result, consumed by the expect lines
    int log_chan [$];
    int log_data [$];

    int              check_count;
    int              error_count;
    int              test_num;
    int              test_checks;
    int              test_errors;
    bit              timed_out;
    int              fd;
    bit              file_done;
    reg [8*128-1:0]  line_buf;

    adc_sampler_top adc_sampler_top_inst (
        .sync_clk_in  (sync_clk_in),
        .reset_in     (reset_in),
        .pair_valid   (pair_valid),
        .raw_a        (raw_a),
        .raw_b        (raw_b),
        .result_valid (result_valid),
        .result_chan  (result_chan),
        .result_data  (result_data),
        .overrun      (overrun)
    );

    // 8 ns clock
    initial begin
        sync_clk_in = 1'b0;
        forever begin
            #4 sync_clk_in = ~sync_clk_in;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checking and model
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < ADC_NUM; i++) begin
            sums[i] = 0;
            cnts[i] = 0;
        end
        pair_k       = 0;
        model_ovr    = 1'b0;
        has_accepted = 1'b0;
        elapsed      = 0;
        pend_chan.delete();
        pend_data.delete();
        log_chan.delete();
        log_data.delete();
    endtask

    // one word into its channel, average once OSR words are in
    task automatic add_sample(input int chan, input int value);
        sums[chan] += value;
        cnts[chan]++;
        if (cnts[chan] == FILT_OSR) begin
            pend_chan.push_back(chan);
            pend_data.push_back(sums[chan] >> FILT_CNT_W);
            log_chan.push_back(chan);
            log_data.push_back(sums[chan] >> FILT_CNT_W);
            sums[chan] = 0;
            cnts[chan] = 0;
        end
    endtask

    // a pair inside the valid hold is dropped and sets the sticky flag
    task automatic model_pair(input int a, input int b);
        if (has_accepted && elapsed <= ADC_DV_HOLD) begin
            model_ovr = 1'b1;
        end else begin
            has_accepted = 1'b1;
            elapsed      = 0;
            add_sample(2 * pair_k, a);
            add_sample(2 * pair_k + 1, b);
            pair_k = (pair_k + 1) % (ADC_NUM / 2);
        end
    endtask

    // results are stable around the falling edge
    always @(negedge sync_clk_in) begin
        if (!reset_in && result_valid) begin
            if (pend_chan.size() == 0) begin
                error_count++;
                $display("unexpected result at %0t ns on channel %0d", $time, result_chan);
            end else begin
                check_value("result_chan", pend_chan.pop_front(), result_chan);
                check_value("result_data", pend_data.pop_front(), result_data);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus, entered 1 ns after a rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic apply_reset();
        reset_in   = 1'b1;
        pair_valid = 1'b0;
        repeat (4) @(posedge sync_clk_in);
        #1;
        reset_in = 1'b0;
        clear_model();
        // nothing may come out before the first pair
        repeat (IDLE_CYCLES) begin
            @(posedge sync_clk_in);
            #1;
            check_value("result_valid", 0, result_valid);
            check_value("overrun", 0, overrun);
        end
    endtask

    task automatic drive_pair(input int a, input int b, input int gap);
        model_pair(a, b);
        pair_valid = 1'b1;
        raw_a      = ADC_DATA_W'(a);
        raw_b      = ADC_DATA_W'(b);
        @(posedge sync_clk_in);
        #1;
        pair_valid = 1'b0;
        check_value("overrun", model_ovr, overrun);
        repeat (gap - 1) begin
            @(posedge sync_clk_in);
            #1;
        end
        elapsed += gap;
    endtask

    task automatic wait_for_results();
        int cycles;
        cycles = 0;
        while (pend_chan.size() > 0 && cycles < DRAIN_LIMIT) begin
            @(posedge sync_clk_in);
            #1;
            cycles++;
        end
        if (pend_chan.size() > 0) begin
            error_count++;
            timed_out = 1'b1;
            $display("timeout: result for channel %0d never arrived", pend_chan[0]);
        end
    endtask

    task automatic check_expect(input int chan, input int avg);
        if (log_chan.size() == 0) begin
            error_count++;
            $display("expect line for channel %0d has no modeled result to match", chan);
        end else begin
            check_value("model result_chan", chan, log_chan.pop_front());
            check_value("model result_data", avg, log_data.pop_front());
        end
    endtask

    task automatic finish_test();
        $display("test %0d finished: %0d checks, %0d errors", test_num,
                 check_count - test_checks, error_count - test_errors);
        test_num++;
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic run_case_line();
        logic [8*8-1:0] kind;
        int             n;
        int             a;
        int             b;
        int             gap;
        kind = '0;
        n    = $sscanf(line_buf, "%s", kind);
        if (n < 1 || kind == "#") begin
            // blank or comment line
        end else if (kind == "pair") begin
            n = $sscanf(line_buf, "%s %h %h %d", kind, a, b, gap);
            if (n != 4 || gap < 1) begin
                error_count++;
                $display("case file has a pair line without a valid gap");
            end else begin
                drive_pair(a, b, gap);
            end
        end else if (kind == "expect") begin
            n = $sscanf(line_buf, "%s %d %h", kind, a, b);
            check_expect(a, b);
        end else if (kind == "reset") begin
            wait_for_results();
            if (!timed_out) begin
                finish_test();
                apply_reset();
            end
        end else begin
            error_count++;
            $display("case file has a line that is not pair, expect or reset");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset_in    = 1'b1;
        pair_valid  = 1'b0;
        raw_a       = '0;
        raw_b       = '0;
        check_count = 0;
        error_count = 0;
        test_num    = 1;
        test_checks = 0;
        test_errors = 0;
        timed_out   = 1'b0;
        clear_model();
        apply_reset();

        fd = $fopen("bench/adc_sampler_cases.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("case file bench/adc_sampler_cases.txt could not be opened");
        end else begin
            file_done = 1'b0;
            while (!file_done) begin
                line_buf = '0;
                if ($fgets(line_buf, fd) == 0) begin
                    file_done = 1'b1;
                end else begin
                    run_case_line();
                    if (timed_out) begin
                        file_done = 1'b1;
                    end
                end
            end
            $fclose(fd);
            if (!timed_out) begin
                wait_for_results();
                // catch stray results after the last one
                repeat (2 * IDLE_CYCLES) begin
                    @(posedge sync_clk_in);
                    #1;
                end
            end
            finish_test();
        end

        $display("%0d tests, %0d checks, %0d errors", test_num - 1, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/adc_sampler_cases.txt ====
# pair <raw_a hex> <raw_b hex> <cycles to next pair>
# expect <channel> <average hex>, and reset restarts the DUT as a new test
# four full scans give every channel four samples
pair 3ffff 00001 6
pair 00010 00100 6
pair 12345 00000 6
pair 0abcd 20000 6
pair 3ffff 00002 6
pair 00020 00200 6
pair 12345 00001 6
pair 0abce 3ffff 6
pair 3ffff 00003 6
pair 00030 00300 6
pair 12345 00002 6
pair 0abcf 00000 6
pair 3ffff 00000 6
pair 00041 00400 6
pair 12345 00003 6
pair 0abd0 1ffff 6
expect 0 3ffff
expect 1 00001
expect 2 00028
expect 3 00280
expect 4 12345
expect 5 00001
expect 6 0abce
expect 7 1ffff
reset
# second pair only two cycles later is dropped and flags overrun
pair 00004 00008 2
pair 3ffff 3ffff 6
pair 00001 00001 6
pair 00001 00001 6
pair 00001 00001 6
pair 00005 00009 6
pair 00001 00001 6
pair 00001 00001 6
pair 00001 00001 6
pair 00006 0000a 6
pair 00001 00001 6
pair 00001 00001 6
pair 00001 00001 6
pair 00007 0000b 6
expect 0 00005
expect 1 00009
# reset with partial sums in channels 2 to 7 and the pair index at 1
reset
pair 00010 00020 6
pair 00002 00002 6
pair 00002 00002 6
pair 00002 00002 6
pair 00011 00021 6
pair 00002 00002 6
pair 00002 00002 6
pair 00002 00002 6
pair 00012 00022 6
pair 00002 00002 6
pair 00002 00002 6
pair 00002 00002 6
pair 00013 00023 6
expect 0 00011
expect 1 00021

// ==== adc_sampler.f ====
hw/adc_cfg_pkg.sv
hw/filter_pkg.sv
hw/adc_pair_capture.sv
hw/clk_sync.sv
hw/oversample_filter.sv
hw/adc_sampler_top.sv
bench/adc_sampler_tb.sv

// ==== Bender.yml ====
package:
  name: adc_sampler

sources:
  # configuration packages
  - hw/adc_cfg_pkg.sv
  - hw/filter_pkg.sv
  # sample path
  - hw/adc_pair_capture.sv
  - hw/clk_sync.sv
  - hw/oversample_filter.sv
  - hw/adc_sampler_top.sv
  # testbench
  - target: test
    files:
      - bench/adc_sampler_tb.sv
